// File: verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // requester side is 32 bits, the memory beat is 64
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [7:0]  strb_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  resp_t;

  // transfer size codes
  localparam size_t SIZE_BYTE = 3'd0;
  localparam size_t SIZE_HALF = 3'd1;
  localparam size_t SIZE_WORD = 3'd2;

  // strobes that map onto a size
  localparam strb_t STRB_BYTE = 8'h01;
  localparam strb_t STRB_HALF = 8'h03;
  localparam strb_t STRB_WORD = 8'h0f;

  // clint mtime, low word then high word
  localparam addr_t RTC_ADDR    = 32'ha000_0048;
  localparam addr_t RTC_ADDR_HI = RTC_ADDR + 32'd4;

  // console transmit register, store only
  localparam addr_t SERIAL_ADDR = 32'ha000_03f8;

endpackage

`default_nettype wire

// File: verilog/dev_pkg.sv
`default_nettype none

package dev_pkg;

  // free-running timer value
  typedef logic [63:0] mtime_t;

  // data bits per serial frame
  localparam int UART_BITS = 8;

  typedef logic [UART_BITS-1:0] uart_byte_t;

  // transmitter frame sequence
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// File: verilog/bus_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module bus_lane_align
  import bus_pkg::*;
(
  // read side
  input  addr_t rd_addr_i,
  input  strb_t rd_strb_i,
  input  beat_t mem_rdata_i,
  output word_t rd_word_o,
  output size_t ar_size_o,

  // write side
  input  addr_t wr_addr_i,
  input  word_t wr_data_i,
  input  strb_t wr_strb_i,
  output beat_t mem_wdata_o,
  output strb_t mem_wstrb_o,
  output size_t aw_size_o
);

  logic wr_upper;

  // only the three aligned strobes have a size of their own
  function automatic size_t strb_to_size(input strb_t strb);
    case (strb)
      STRB_BYTE: strb_to_size = SIZE_BYTE;
      STRB_HALF: strb_to_size = SIZE_HALF;
      STRB_WORD: strb_to_size = SIZE_WORD;
      default:   strb_to_size = SIZE_BYTE;
    endcase
  endfunction

  assign ar_size_o = strb_to_size(rd_strb_i);
  assign aw_size_o = strb_to_size(wr_strb_i);

  // bit 2 picks the lane of the beat
  assign rd_word_o = rd_addr_i[2] ? mem_rdata_i[63:32] : mem_rdata_i[31:0];

  // word stores to the odd word move up one lane
  assign wr_upper = wr_addr_i[2] && (wr_strb_i == STRB_WORD);

  assign mem_wdata_o = wr_upper ? {wr_data_i, word_t'(0)} : {word_t'(0), wr_data_i};
  assign mem_wstrb_o = wr_upper ? {wr_strb_i[3:0], 4'h0} : wr_strb_i;

endmodule

`default_nettype wire

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // instruction fetch
  input  logic  ifu_arvalid_i,
  input  addr_t ifu_araddr_i,
  output logic  ifu_rvalid_o,
  output word_t ifu_rdata_o,

  // loads
  input  logic  lsu_arvalid_i,
  input  addr_t lsu_araddr_i,
  output logic  lsu_rvalid_o,
  output word_t lsu_rdata_o,

  // targets
  output addr_t rd_addr_o,
  output logic  mem_rd_o,
  input  logic  mem_rd_done_i,
  input  word_t mem_rd_data_i,
  output logic  clint_rd_o,
  input  logic  clint_rvalid_i,
  input  word_t clint_rdata_i
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_IFU,
    GNT_LSU
  } grant_e;

  grant_e grant_q;
  grant_e grant_new;
  grant_e owner;
  logic   issue;
  logic   clint_hit;
  logic   rsp_valid;
  word_t  rsp_data;

  // lsu wins whenever a fresh grant is made
  always_comb
  begin
    if (lsu_arvalid_i)
    begin
      grant_new = GNT_LSU;
    end
    else if (ifu_arvalid_i)
    begin
      grant_new = GNT_IFU;
    end
    else
    begin
      grant_new = GNT_NONE;
    end
  end

  // held grant wins over a new request
  assign owner = (grant_q == GNT_NONE) ? grant_new : grant_q;
  assign issue = (grant_q == GNT_NONE) && (grant_new != GNT_NONE);

  assign rd_addr_o = (owner == GNT_IFU) ? ifu_araddr_i : lsu_araddr_i;

  // the timer window is reachable by loads only
  assign clint_hit = (owner == GNT_LSU) &&
                     ((rd_addr_o == RTC_ADDR) || (rd_addr_o == RTC_ADDR_HI));

  assign mem_rd_o   = (owner != GNT_NONE) && !clint_hit;
  // one-cycle pulse, the clint registers it on the grant edge
  assign clint_rd_o = issue && clint_hit;

  assign rsp_valid = clint_hit ? clint_rvalid_i : mem_rd_done_i;
  assign rsp_data  = clint_hit ? clint_rdata_i : mem_rd_data_i;

  // data goes to both, the valid tells who owns it
  assign ifu_rdata_o  = rsp_data;
  assign lsu_rdata_o  = rsp_data;
  assign ifu_rvalid_o = (grant_q == GNT_IFU) && rsp_valid;
  assign lsu_rvalid_o = (grant_q == GNT_LSU) && rsp_valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_q <= GNT_NONE;
    end
    else if ((grant_q != GNT_NONE) && rsp_valid)
    begin
      grant_q <= GNT_NONE;
    end
    else if (issue)
    begin
      grant_q <= grant_new;
    end
  end

endmodule

`default_nettype wire

// File: verilog/bus_clint.sv
`timescale 1ns/1ps
`default_nettype none

module bus_clint
  import bus_pkg::*, dev_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_i,
  input  logic  rd_high_i,
  output logic  rvalid_o,
  output word_t rdata_o
);

  mtime_t mtime_q;

  // counts every edge once out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + mtime_t'(1);
      rvalid_o <= rd_i;
    end
  end

  // sample the half as of the request edge
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      rdata_o <= rd_high_i ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

endmodule

`default_nettype wire

// File: verilog/bus_uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module bus_uart_tx
  import dev_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr_i,
  input  uart_byte_t wr_data_i,
  output logic       idle_o,
  output logic       tx_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(UART_BITS);

  uart_state_e      state_q;
  logic [CNT_W-1:0] baud_cnt_q;
  logic [IDX_W-1:0] bit_idx_q;
  uart_byte_t       shift_q;
  logic             baud_tick;

  // last cycle of the current bit period
  assign baud_tick = baud_cnt_q == CNT_W'(CLKS_PER_BIT - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= UART_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
    end
    else
    begin
      baud_cnt_q <= (state_q == UART_IDLE || baud_tick) ? '0 : baud_cnt_q + CNT_W'(1);
      case (state_q)
        UART_IDLE:
        begin
          bit_idx_q <= '0;
          if (wr_i)
            state_q <= UART_START;
        end
        UART_START:
        begin
          if (baud_tick)
            state_q <= UART_DATA;
        end
        UART_DATA:
        begin
          if (baud_tick)
          begin
            bit_idx_q <= bit_idx_q + IDX_W'(1);
            if (bit_idx_q == IDX_W'(UART_BITS - 1))
              state_q <= UART_STOP;
          end
        end
        default:
        begin
          if (baud_tick)
            state_q <= UART_IDLE;
        end
      endcase
    end
  end

  // lsb goes out first
  always_ff @(posedge clk)
  begin
    if (state_q == UART_IDLE && wr_i)
      shift_q <= wr_data_i;
    else if (state_q == UART_DATA && baud_tick)
      shift_q <= shift_q >> 1;
  end

  assign idle_o = state_q == UART_IDLE;
  assign tx_o   = (state_q == UART_START) ? 1'b0 :
                  (state_q == UART_DATA)  ? shift_q[0] : 1'b1;

endmodule

`default_nettype wire

// File: verilog/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top
  import bus_pkg::*, dev_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic  clk,
  input  logic  rst,
  // fetch and load requesters
  input  logic  ifu_arvalid_i,
  input  addr_t ifu_araddr_i,
  output logic  ifu_rvalid_o,
  output word_t ifu_rdata_o,
  input  logic  lsu_arvalid_i,
  input  addr_t lsu_araddr_i,
  input  strb_t lsu_rstrb_i,
  output logic  lsu_rvalid_o,
  output word_t lsu_rdata_o,
  // stores
  input  logic  lsu_wvalid_i,
  input  addr_t lsu_awaddr_i,
  input  word_t lsu_wdata_i,
  input  strb_t lsu_wstrb_i,
  output logic  lsu_wready_o,
  // external memory
  output logic  mem_arvalid_o,
  output addr_t mem_araddr_o,
  output size_t mem_arsize_o,
  input  logic  mem_arready_i,
  input  logic  mem_rvalid_i,
  input  beat_t mem_rdata_i,
  input  resp_t mem_rresp_i,
  output logic  mem_awvalid_o,
  output addr_t mem_awaddr_o,
  output size_t mem_awsize_o,
  input  logic  mem_awready_i,
  output logic  mem_wvalid_o,
  output beat_t mem_wdata_o,
  output strb_t mem_wstrb_o,
  output logic  mem_wlast_o,
  input  logic  mem_wready_i,
  input  logic  mem_bvalid_i,
  input  resp_t mem_bresp_i,
  output logic  uart_tx_o
);

  addr_t      rd_addr;
  word_t      rd_word;
  word_t      clint_rdata;
  logic       mem_rd;
  logic       clint_rd;
  logic       clint_rvalid;
  logic       sent_q;
  logic       serial_hit;
  logic       uart_idle;
  uart_byte_t serial_byte;

  bus_arbiter i_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .ifu_rdata_o    (ifu_rdata_o),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .rd_addr_o      (rd_addr),
    .mem_rd_o       (mem_rd),
    .mem_rd_done_i  (mem_rvalid_i),
    .mem_rd_data_i  (rd_word),
    .clint_rd_o     (clint_rd),
    .clint_rvalid_i (clint_rvalid),
    .clint_rdata_i  (clint_rdata)
  );

  // read size follows the load strobe
  bus_lane_align i_align (
    .rd_addr_i   (rd_addr),
    .rd_strb_i   (lsu_rstrb_i),
    .mem_rdata_i (mem_rdata_i),
    .rd_word_o   (rd_word),
    .ar_size_o   (mem_arsize_o),
    .wr_addr_i   (lsu_awaddr_i),
    .wr_data_i   (lsu_wdata_i),
    .wr_strb_i   (lsu_wstrb_i),
    .mem_wdata_o (mem_wdata_o),
    .mem_wstrb_o (mem_wstrb_o),
    .aw_size_o   (mem_awsize_o)
  );

  bus_clint i_clint (
    .clk       (clk),
    .rst       (rst),
    .rd_i      (clint_rd),
    .rd_high_i (rd_addr[2]),
    .rvalid_o  (clint_rvalid),
    .rdata_o   (clint_rdata)
  );

  // address channel drops once the beat is accepted
  always_ff @(posedge clk)
  begin
    if (rst || mem_rvalid_i)
      sent_q <= 1'b0;
    else if (mem_arvalid_o && mem_arready_i)
      sent_q <= 1'b1;
  end

  assign mem_arvalid_o = mem_rd && !sent_q;
  assign mem_araddr_o  = rd_addr;

  // stores go to the console or to memory
  assign serial_hit    = lsu_awaddr_i == SERIAL_ADDR;
  assign serial_byte   = lsu_wdata_i[UART_BITS-1:0];
  assign mem_awvalid_o = lsu_wvalid_i && !serial_hit;
  assign mem_wvalid_o  = mem_awvalid_o;
  assign mem_wlast_o   = mem_wvalid_o;
  assign mem_awaddr_o  = lsu_awaddr_i;
  assign lsu_wready_o  = serial_hit ? uart_idle : (mem_awready_i && mem_wready_i);

  bus_uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (lsu_wvalid_i && serial_hit),
    .wr_data_i (serial_byte),
    .idle_o    (uart_idle),
    .tx_o      (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_checker
  import bus_pkg::*, dev_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  ifu_arvalid_i,
  input  addr_t ifu_araddr_i,
  input  logic  ifu_rvalid_i,
  input  word_t ifu_rdata_i,
  input  logic  lsu_arvalid_i,
  input  addr_t lsu_araddr_i,
  input  strb_t lsu_rstrb_i,
  input  logic  lsu_rvalid_i,
  input  word_t lsu_rdata_i,
  input  logic  lsu_wvalid_i,
  input  addr_t lsu_awaddr_i,
  input  word_t lsu_wdata_i,
  input  strb_t lsu_wstrb_i,
  input  logic  lsu_wready_i,
  input  logic  mem_arvalid_i,
  input  addr_t mem_araddr_i,
  input  size_t mem_arsize_i,
  input  logic  mem_awvalid_i,
  input  addr_t mem_awaddr_i,
  input  size_t mem_awsize_i,
  input  logic  mem_awready_i,
  input  logic  mem_wvalid_i,
  input  beat_t mem_wdata_i,
  input  strb_t mem_wstrb_i,
  input  logic  mem_wlast_i,
  input  logic  mem_wready_i,
  input  logic  uart_tx_i,
  output int    mismatch_count_o,
  output int    failure_count_o
);

  localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;

  beat_t      model [0:511];
  mtime_t     cycle_q;
  mtime_t     clint_time;
  logic       clint_due;
  logic       pend_ifu;
  logic       pend_lsu;
  logic       lsu_first;
  int         frame_left;
  uart_byte_t frame_byte;

  function automatic beat_t initial_beat(input int idx);
    return {32'(idx) * 32'h9e37_79b9, ~(32'(idx) * 32'h85eb_ca6b)};
  endfunction

  function automatic word_t model_word(input addr_t a);
    return a[2] ? model[a[11:3]][63:32] : model[a[11:3]][31:0];
  endfunction

  function automatic size_t expected_size(input strb_t s);
    return (s == 8'h01) ? 3'd0 : (s == 8'h03) ? 3'd1 : (s == 8'h0f) ? 3'd2 : 3'd0;
  endfunction

  function automatic logic is_rtc(input addr_t a);
    return (a == 32'ha000_0048) || (a == 32'ha000_004c);
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      mismatch_count_o++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    failure_count_o++;
    $display("error: %s at %0t", msg, $time);
  endtask

  initial
  begin
    mismatch_count_o = 0;
    failure_count_o  = 0;
    for (int i = 0; i < 512; i++)
      model[i] = initial_beat(i);
  end

  always @(posedge clk)
  begin : watch
    logic  new_lsu;
    logic  new_ifu;
    logic  upper;
    logic  serial;
    logic  mem_store;
    beat_t exp_data;
    strb_t exp_strb;
    int    elapsed;
    int    bit_pos;
    logic  exp_tx;
    if (rst)
    begin
      cycle_q    <= '0;
      clint_due  <= 1'b0;
      pend_ifu   <= 1'b0;
      pend_lsu   <= 1'b0;
      lsu_first  <= 1'b0;
      frame_left <= 0;
    end
    else
    begin
      cycle_q <= cycle_q + 1;
      new_lsu = lsu_arvalid_i && !pend_lsu;
      new_ifu = ifu_arvalid_i && !pend_ifu;

      if (lsu_rvalid_i)
      begin
        if (!pend_lsu)
          report_failure("lsu got a read response it did not request");
        else if (pend_ifu && !lsu_first)
          report_failure("lsu was served before the granted ifu read");
        if (is_rtc(lsu_araddr_i))
        begin
          if (!clint_due)
            report_failure("clint response not exactly one cycle after accept");
          else
            compare_value("lsu_rdata_o", lsu_rdata_i,
                          lsu_araddr_i[2] ? clint_time[63:32] : clint_time[31:0]);
        end
        else
          compare_value("lsu_rdata_o", lsu_rdata_i, model_word(lsu_araddr_i));
        pend_lsu <= 1'b0;
      end
      else if (clint_due)
        report_failure("clint read gave no response one cycle after accept");
      else if (new_lsu)
        pend_lsu <= 1'b1;
      clint_due  <= new_lsu && is_rtc(lsu_araddr_i);
      clint_time <= cycle_q;

      if (ifu_rvalid_i)
      begin
        if (!pend_ifu)
          report_failure("ifu got a read response it did not request");
        else if (pend_lsu && lsu_first)
          report_failure("ifu was served before the lsu");
        compare_value("ifu_rdata_o", ifu_rdata_i, model_word(ifu_araddr_i));
        pend_ifu <= 1'b0;
      end
      else if (new_ifu)
        pend_ifu <= 1'b1;

      // lsu wins a tie and otherwise the earlier request goes first
      if (new_lsu && !pend_ifu)
        lsu_first <= 1'b1;
      else if (new_ifu && !pend_lsu)
        lsu_first <= 1'b0;

      // timer reads never reach the memory port
      if (lsu_arvalid_i && !ifu_arvalid_i && is_rtc(lsu_araddr_i))
        compare_value("mem_arvalid_o", mem_arvalid_i, 1'b0);
      else if (mem_arvalid_i && lsu_arvalid_i && !ifu_arvalid_i)
      begin
        compare_value("mem_arsize_o", mem_arsize_i, expected_size(lsu_rstrb_i));
        compare_value("mem_araddr_o", mem_araddr_i, lsu_araddr_i);
      end
      else if (mem_arvalid_i && ifu_arvalid_i && !lsu_arvalid_i)
        compare_value("mem_araddr_o", mem_araddr_i, ifu_araddr_i);

      serial    = lsu_awaddr_i == SERIAL_ADDR;
      mem_store = lsu_wvalid_i && !serial;

      // both store channels and the last flag go with a memory store
      compare_value("mem_awvalid_o", mem_awvalid_i, mem_store);
      compare_value("mem_wvalid_o", mem_wvalid_i, mem_store);
      compare_value("mem_wlast_o", mem_wlast_i, mem_store);
      if (mem_store)
        compare_value("lsu_wready_o", lsu_wready_i, mem_awready_i && mem_wready_i);

      if (mem_store && lsu_wready_i)
      begin
        upper    = lsu_awaddr_i[2] && (lsu_wstrb_i == 8'h0f);
        exp_data = upper ? {lsu_wdata_i, 32'h0} : {32'h0, lsu_wdata_i};
        exp_strb = upper ? {lsu_wstrb_i[3:0], 4'h0} : lsu_wstrb_i;
        compare_value("mem_awaddr_o", mem_awaddr_i, lsu_awaddr_i);
        compare_value("mem_wdata_o", mem_wdata_i, exp_data);
        compare_value("mem_wstrb_o", mem_wstrb_i, exp_strb);
        compare_value("mem_awsize_o", mem_awsize_i, expected_size(lsu_wstrb_i));
        for (int b = 0; b < 8; b++)
        begin
          if (exp_strb[b])
            model[lsu_awaddr_i[11:3]][8*b +: 8] = exp_data[8*b +: 8];
        end
      end

      if (lsu_wvalid_i && serial)
      begin
        if (frame_left > 0 && lsu_wready_i)
          report_failure("serial store accepted while a frame is in progress");
        if (frame_left == 0 && !lsu_wready_i)
          report_failure("serial store held off while the uart is idle");
      end

      // sample each bit in the middle of its period
      if (frame_left > 0)
      begin
        elapsed = FRAME_CYCLES - frame_left;
        bit_pos = elapsed / CLKS_PER_BIT;
        if (elapsed % CLKS_PER_BIT == CLKS_PER_BIT / 2)
        begin
          exp_tx = (bit_pos == 0) ? 1'b0 : (bit_pos == 9) ? 1'b1 : frame_byte[bit_pos-1];
          compare_value("uart_tx_o", uart_tx_i, exp_tx);
        end
        frame_left <= frame_left - 1;
      end
      else
      begin
        compare_value("uart_tx_o", uart_tx_i, 1'b1);
        if (lsu_wvalid_i && serial && lsu_wready_i)
        begin
          frame_left <= FRAME_CYCLES;
          frame_byte <= lsu_wdata_i[7:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_bus_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_assert
  import bus_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  ifu_rvalid_o,
  input logic  lsu_rvalid_o,
  input logic  mem_arvalid_o,
  input logic  mem_arready_i,
  input logic  mem_rvalid_i,
  input resp_t mem_rresp_i,
  input logic  mem_awvalid_o,
  input logic  mem_wvalid_o,
  input logic  mem_awready_i,
  input logic  mem_wready_i,
  input logic  mem_bvalid_i,
  input resp_t mem_bresp_i
);

  logic seen_edge = 1'b0;

  // grant state is unknown before the first edge
  always @(posedge clk)
    seen_edge <= 1'b1;

  a_rresp_ok: assert property (@(posedge clk) mem_rvalid_i |-> mem_rresp_i == 2'b00)
    else $error("read response not okay");

  a_bresp_ok: assert property (@(posedge clk) mem_bvalid_i |-> mem_bresp_i == 2'b00)
    else $error("write response not okay");

  a_quiet_in_reset: assert property (@(posedge clk) (rst && seen_edge) |->
      !(mem_arvalid_o || mem_awvalid_o || mem_wvalid_o || ifu_rvalid_o || lsu_rvalid_o))
    else $error("valid output high during reset");

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      (mem_arvalid_o && !mem_arready_i) |=> mem_arvalid_o)
    else $error("mem_arvalid_o dropped before mem_arready_i");

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      (mem_awvalid_o && !(mem_awready_i && mem_wready_i)) |=> mem_awvalid_o)
    else $error("mem_awvalid_o dropped before the store was accepted");

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
      (mem_wvalid_o && !(mem_awready_i && mem_wready_i)) |=> mem_wvalid_o)
    else $error("mem_wvalid_o dropped before the store was accepted");

endmodule

bind bus_top tb_bus_assert i_assert (.*);

`default_nettype wire

// File: testbench/tb_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_top
  import bus_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
);

  localparam int NUM_OPS     = 600;
  localparam int CYCLE_LIMIT = 16 + NUM_OPS * (60 + 10 * CLKS_PER_BIT);

  logic  clk;
  logic  rst;
  logic  ifu_arvalid_i;
  addr_t ifu_araddr_i;
  logic  ifu_rvalid_o;
  word_t ifu_rdata_o;
  logic  lsu_arvalid_i;
  addr_t lsu_araddr_i;
  strb_t lsu_rstrb_i;
  logic  lsu_rvalid_o;
  word_t lsu_rdata_o;
  logic  lsu_wvalid_i;
  addr_t lsu_awaddr_i;
  word_t lsu_wdata_i;
  strb_t lsu_wstrb_i;
  logic  lsu_wready_o;
  logic  mem_arvalid_o;
  addr_t mem_araddr_o;
  size_t mem_arsize_o;
  logic  mem_arready_i;
  logic  mem_rvalid_i;
  beat_t mem_rdata_i;
  resp_t mem_rresp_i;
  logic  mem_awvalid_o;
  addr_t mem_awaddr_o;
  size_t mem_awsize_o;
  logic  mem_awready_i;
  logic  mem_wvalid_o;
  beat_t mem_wdata_o;
  strb_t mem_wstrb_o;
  logic  mem_wlast_o;
  logic  mem_wready_i;
  logic  mem_bvalid_i;
  resp_t mem_bresp_i;
  logic  uart_tx_o;

  int    mismatch_count;
  int    failure_count;
  int    cycles;
  logic [31:0] stim_rng;
  logic [31:0] resp_rng;
  beat_t mem [0:511];
  logic  ar_taken;
  addr_t ar_taken_addr;
  logic  w_taken;
  int    rd_left;
  addr_t rd_addr;
  addr_t last_store;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = lcg_step(stim_rng);
    return stim_rng ^ (stim_rng >> 15);
  endfunction

  function automatic logic [31:0] next_resp();
    resp_rng = lcg_step(resp_rng);
    return resp_rng ^ (resp_rng >> 15);
  endfunction

  // memory contents before any store depend on the whole beat index
  function automatic beat_t initial_beat(input int idx);
    return {32'(idx) * 32'h9e37_79b9, ~(32'(idx) * 32'h85eb_ca6b)};
  endfunction

  bus_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_dut (.*);

  tb_bus_checker #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_checker (
    .clk             (clk),
    .rst             (rst),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_araddr_i    (ifu_araddr_i),
    .ifu_rvalid_i    (ifu_rvalid_o),
    .ifu_rdata_i     (ifu_rdata_o),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_araddr_i    (lsu_araddr_i),
    .lsu_rstrb_i     (lsu_rstrb_i),
    .lsu_rvalid_i    (lsu_rvalid_o),
    .lsu_rdata_i     (lsu_rdata_o),
    .lsu_wvalid_i    (lsu_wvalid_i),
    .lsu_awaddr_i    (lsu_awaddr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_wstrb_i     (lsu_wstrb_i),
    .lsu_wready_i    (lsu_wready_o),
    .mem_arvalid_i   (mem_arvalid_o),
    .mem_araddr_i    (mem_araddr_o),
    .mem_arsize_i    (mem_arsize_o),
    .mem_awvalid_i   (mem_awvalid_o),
    .mem_awaddr_i    (mem_awaddr_o),
    .mem_awsize_i    (mem_awsize_o),
    .mem_awready_i   (mem_awready_i),
    .mem_wvalid_i    (mem_wvalid_o),
    .mem_wdata_i     (mem_wdata_o),
    .mem_wstrb_i     (mem_wstrb_o),
    .mem_wlast_i     (mem_wlast_o),
    .mem_wready_i    (mem_wready_i),
    .uart_tx_i       (uart_tx_o),
    .mismatch_count_o (mismatch_count),
    .failure_count_o  (failure_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // handshakes as seen at the edge and the beat array writes
  always @(posedge clk)
  begin : mem_capture
    int b;
    ar_taken      <= !rst && mem_arvalid_o && mem_arready_i;
    ar_taken_addr <= mem_araddr_o;
    w_taken       <= !rst && mem_awvalid_o && mem_awready_i && mem_wready_i;
    if (!rst && mem_awvalid_o && mem_awready_i && mem_wready_i)
    begin
      for (b = 0; b < 8; b++)
      begin
        if (mem_wstrb_o[b])
          mem[mem_awaddr_o[11:3]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
      end
    end
  end

  // responder with 1 to 6 cycles of read latency and random ready stalls
  always @(negedge clk)
  begin
    mem_rvalid_i = 1'b0;
    mem_bvalid_i = w_taken;
    if (ar_taken)
    begin
      rd_left = 1 + int'(next_resp() % 6);
      rd_addr = ar_taken_addr;
    end
    if (rd_left > 0)
    begin
      rd_left--;
      if (rd_left == 0)
      begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem[rd_addr[11:3]];
      end
    end
    mem_arready_i = !ar_taken && (rd_left == 0) && !mem_rvalid_i && (next_resp() % 4 != 0);
    mem_awready_i = next_resp() % 4 != 0;
    mem_wready_i  = next_resp() % 5 != 0;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: test still running after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic addr_t mem_addr(input logic [31:0] r);
    return {20'h0, r[11:2], 2'b00};
  endfunction

  task automatic read_lsu(input addr_t a, input strb_t s);
    @(negedge clk);
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = a;
    lsu_rstrb_i   = s;
    do @(posedge clk); while (!lsu_rvalid_o);
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic read_ifu(input addr_t a);
    @(negedge clk);
    ifu_arvalid_i = 1'b1;
    ifu_araddr_i  = a;
    do @(posedge clk); while (!ifu_rvalid_o);
    @(negedge clk);
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic store(input addr_t a, input word_t d, input strb_t s);
    @(negedge clk);
    lsu_wvalid_i = 1'b1;
    lsu_awaddr_i = a;
    lsu_wdata_i  = d;
    lsu_wstrb_i  = s;
    do @(posedge clk); while (!lsu_wready_o);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
  endtask

  task automatic run_op();
    logic [31:0] r;
    logic [31:0] r2;
    addr_t       a;
    strb_t       s;
    r  = next_stim();
    r2 = next_stim();
    a  = mem_addr(r2);
    s  = (r[5:4] == 2'd0) ? STRB_BYTE : (r[5:4] == 2'd1) ? STRB_HALF :
         (r[5:4] == 2'd2) ? STRB_WORD : 8'h07;
    case (r[2:0])
      3'd0, 3'd1: read_lsu(a, s);
      3'd2: read_lsu(last_store, STRB_WORD);
      3'd3: read_ifu(a);
      3'd4:
      begin
        // both requesters together or with the fetch one cycle ahead
        if (r[3])
          fork
            read_ifu(mem_addr(r2 >> 10));
            read_lsu(a, STRB_WORD);
          join
        else
          fork
            read_ifu(mem_addr(r2 >> 10));
            begin
              @(negedge clk);
              read_lsu(a, STRB_WORD);
            end
          join
      end
      3'd5: read_lsu(r[3] ? RTC_ADDR_HI : RTC_ADDR, STRB_WORD);
      3'd6:
      begin
        if (s != STRB_WORD)
          a[2] = 1'b0;
        if (s == 8'h07)
          s = STRB_HALF;
        last_store = a;
        store(a, next_stim(), s);
      end
      default: store(SERIAL_ADDR, next_stim(), STRB_BYTE);
    endcase
  endtask

  initial
  begin
    stim_rng      = 32'hf0a2_b35f;
    resp_rng      = 32'hf0a2_b35f ^ 32'h5bd1_e995;
    cycles        = 0;
    rd_left       = 0;
    last_store    = '0;
    rst           = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    mem_arready_i = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    mem_rresp_i   = '0;
    mem_awready_i = 1'b0;
    mem_wready_i  = 1'b0;
    mem_bvalid_i  = 1'b0;
    mem_bresp_i   = '0;
    for (int i = 0; i < 512; i++)
      mem[i] = initial_beat(i);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int op = 0; op < NUM_OPS; op++)
      run_op();
    // let the last serial frame finish
    repeat (10 * CLKS_PER_BIT + 8) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/bus_pkg.sv
verilog/dev_pkg.sv
verilog/bus_lane_align.sv
verilog/bus_arbiter.sv
verilog/bus_clint.sv
verilog/bus_uart_tx.sv
verilog/bus_top.sv
testbench/tb_bus_checker.sv
testbench/tb_bus_assert.sv
testbench/tb_bus_top.sv
